// ==== logic/hisPkg.sv ====
package hisPkg;

    // raw tdc code width
    localparam int Np = 10;

    // bin address width, 32 bins per histogram
    localparam int Nb = 5;
    localparam int NUM_BINS = 2 ** Nb;

    // bin count width, counts stick at all ones
    localparam int peakMax = 8;

    // coarse pass covers the whole code range
    localparam int COARSE_BIN_WIDTH = 32;

    // fine pass covers a narrow window only
    localparam int FINE_BIN_WIDTH = 2;
    localparam int FINE_SPAN = 64;

    // accepted codes per pass
    localparam int SAMPLES_PER_HIS = 64;

    // sweep counter width, must hold SAMPLES_PER_HIS-1 and NUM_BINS
    localparam int CNT_W = 7;

    // controller phases in the order they run
    typedef enum logic [2:0] {
        clearCoarse,
        acqCoarse,
        scanCoarse,
        calcWindow,
        clearFine,
        acqFine,
        scanFine,
        report
    } hisState;

endpackage

// ==== logic/dataFolder.sv ====
`timescale 1ns/1ns

module dataFolder
    import hisPkg::*;
(
    input  logic [Np-1:0] sampleData,
    input  logic          hisNum,
    input  logic [Np-1:0] thMinus,
    input  logic [Np-1:0] thPositive,
    output logic [Nb-1:0] binAddr,
    output logic          inWindow
);

    logic [Nb-1:0] coarseAddr;
    logic [Nb-1:0] fineAddr;
    logic [Np-1:0] fineOffset;
    logic          aboveMin;
    logic          belowMax;

    // coarse bin, plain divide over the full range
    assign coarseAddr = Nb'(sampleData / COARSE_BIN_WIDTH);

    // distance from window start, only meaningful inside the window
    assign fineOffset = sampleData - thMinus;

    // fine bin inside the window
    assign fineAddr = Nb'(fineOffset / FINE_BIN_WIDTH);

    // both window edges are inclusive
    assign aboveMin = (sampleData >= thMinus);
    assign belowMax = (sampleData <= thPositive);

    always_comb begin
        if (hisNum) begin
            // fine pass
            binAddr  = fineAddr;
            inWindow = aboveMin && belowMax;
        end else begin
            // coarse pass, every code lands in some bin
            binAddr  = coarseAddr;
            inWindow = 1'b1;
        end
    end

    // NOTE out-of-window codes still get a fine address, but the memory
    // drops them, so whatever wrapped value appears here is harmless

endmodule

// ==== logic/hisCounter.sv ====
`timescale 1ns/1ns

module hisCounter
    import hisPkg::*;
(
    input  logic             clk,
    input  logic             rstN,
    input  logic             cntClear,
    input  logic             cntEn,
    input  logic [CNT_W-1:0] cntTerm,
    output logic [CNT_W-1:0] cntIdx,
    output logic             cntLast
);

    // terminal flag follows the live term from the controller
    assign cntLast = (cntIdx == cntTerm);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cntIdx <= '0;
        end else if (cntClear) begin
            // clear wins over enable
            cntIdx <= '0;
        end else if (cntEn) begin
            cntIdx <= cntIdx + CNT_W'(1);
        end
    end

    // one counter serves three jobs:
    //   clear sweep   0 .. NUM_BINS-1
    //   sample count  0 .. SAMPLES_PER_HIS-1, steps on transfers only
    //   scan sweep    0 .. NUM_BINS, parks at the end

endmodule

// ==== logic/binMemory.sv ====
`timescale 1ns/1ns

module binMemory
    import hisPkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  logic               clrEn,
    input  logic               incEn,
    input  logic               scanEn,
    input  logic [Nb-1:0]      binAddr,
    input  logic               inWindow,
    input  logic [Nb-1:0]      cntIdx,
    output logic [peakMax-1:0] binCount,
    output logic               countValid
);

    logic [peakMax-1:0] mem [NUM_BINS];

    // increment waiting for its write
    logic               pendValid;
    logic [Nb-1:0]      pendAddr;
    logic [peakMax-1:0] pendCount;

    logic               doInc;
    logic [peakMax-1:0] incBase;
    logic [peakMax-1:0] incNext;
    logic [peakMax-1:0] scanData;

    assign doInc = incEn && inWindow;

    // forward the pending value when the same bin comes right back
    assign incBase = (pendValid && (pendAddr == binAddr)) ? pendCount : mem[binAddr];

    // saturate at all ones
    assign incNext = (&incBase) ? incBase : incBase + 1'b1;

    // scan can start while the last increment is still in flight
    assign scanData = (pendValid && (pendAddr == cntIdx)) ? pendCount : mem[cntIdx];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pendValid  <= 1'b0;
            countValid <= 1'b0;
        end else begin
            pendValid  <= doInc;
            countValid <= scanEn;
        end
    end

    always_ff @(posedge clk) begin
        // read side of the rmw, taken in the transfer cycle
        if (doInc) begin
            pendAddr  <= binAddr;
            pendCount <= incNext;
        end
        // write side, one edge later
        if (pendValid) begin
            mem[pendAddr] <= pendCount;
        end
        // clear sweep, one bin per cycle
        if (clrEn) begin
            mem[cntIdx] <= '0;
        end
        // scan read, one cycle latency
        if (scanEn) begin
            binCount <= scanData;
        end
    end

endmodule

// ==== logic/peakDetecter.sv ====
`timescale 1ns/1ns

module peakDetecter
    import hisPkg::*;
(
    input  logic               clk,
    input  logic               rstN,
    input  logic               scanStart,
    input  logic [peakMax-1:0] binCount,
    input  logic               countValid,
    output logic [Nb-1:0]      peakIdx,
    output logic               peakDone
);

    // running maximum of this scan
    logic [peakMax-1:0] maxCount;

    // bin index of the count now on the input
    logic [Nb-1:0] scanIdx;

    logic lastCount;
    logic newPeak;

    assign lastCount = countValid && (scanIdx == Nb'(NUM_BINS - 1));

    // strictly greater, so the lowest index keeps a tie
    assign newPeak = countValid && (binCount > maxCount);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            maxCount <= '0;
            peakIdx  <= '0;
            scanIdx  <= '0;
            peakDone <= 1'b0;
        end else begin
            // one pulse, after the last bin is compared
            peakDone <= lastCount;
            if (scanStart) begin
                // empty histogram leaves index 0
                maxCount <= '0;
                peakIdx  <= '0;
                scanIdx  <= '0;
            end else if (countValid) begin
                scanIdx <= scanIdx + 1'b1;
                if (newPeak) begin
                    maxCount <= binCount;
                    peakIdx  <= scanIdx;
                end
            end
        end
    end

    // peakIdx holds after the scan
    // the coarse result is still needed in calcWindow

endmodule

// ==== logic/algebraicBlock.sv ====
`timescale 1ns/1ns

module algebraicBlock
    import hisPkg::*;
(
    input  logic          clk,
    input  logic          rstN,
    input  logic          winLoad,
    input  logic [Nb-1:0] peakIdx,
    output logic [Np-1:0] thMinus,
    output logic [Np-1:0] thPositive
);

    int            rawStart;
    logic [Np-1:0] clampStart;

    always_comb begin
        // window centred on the middle of the coarse peak bin
        rawStart = int'(peakIdx) * COARSE_BIN_WIDTH + COARSE_BIN_WIDTH / 2 - FINE_SPAN / 2;
        // keep the whole window inside the code range
        if (rawStart < 0) begin
            clampStart = '0;
        end else if (rawStart > (2 ** Np) - FINE_SPAN) begin
            clampStart = Np'((2 ** Np) - FINE_SPAN);
        end else begin
            clampStart = Np'(rawStart);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            thMinus    <= '0;
            thPositive <= '0;
        end else if (winLoad) begin
            thMinus    <= clampStart;
            // inclusive top edge
            thPositive <= clampStart + Np'(FINE_SPAN - 1);
        end
    end

endmodule

// ==== logic/hisBuilderFsm.sv ====
`timescale 1ns/1ns

module hisBuilderFsm
    import hisPkg::*;
(
    input  logic             clk,
    input  logic             rstN,
    input  logic             sampleValid,
    output logic             sampleReady,
    output logic             resultValid,
    input  logic             resultReady,
    output logic [Np-1:0]    resultCode,
    input  logic             cntLast,
    output logic             cntClear,
    output logic             cntEn,
    output logic [CNT_W-1:0] cntTerm,
    output logic             hisNum,
    output logic             clrEn,
    output logic             incEn,
    output logic             scanEn,
    output logic             scanStart,
    input  logic             peakDone,
    input  logic [Nb-1:0]    peakIdx,
    input  logic [Np-1:0]    thMinus,
    output logic             winLoad
);

    hisState state;
    hisState nextState;
    logic    transfer;
    logic    inScan;

    // input handshake only in the two acquire phases
    assign sampleReady = (state == acqCoarse) || (state == acqFine);
    assign transfer    = sampleValid && sampleReady;

    // result sits on the port for as long as report lasts
    assign resultValid = (state == report);

    // fine side runs from clearFine up to report
    assign hisNum = state inside {clearFine, acqFine, scanFine, report};

    assign inScan = (state == scanCoarse) || (state == scanFine);

    // memory controls
    assign clrEn  = (state == clearCoarse) || (state == clearFine);
    assign incEn  = transfer;
    // reads stop once the index reaches NUM_BINS
    assign scanEn = inScan && !cntLast;

    // detector restarts on the way into each scan
    assign scanStart = (state != nextState)
                    && ((nextState == scanCoarse) || (nextState == scanFine));

    assign winLoad = (state == calcWindow);

    // counter restarts at every phase change
    assign cntClear = (state != nextState);
    assign cntEn    = clrEn || transfer || scanEn;

    // terminal count per phase
    always_comb begin
        case (state)
            clearCoarse, clearFine: cntTerm = CNT_W'(NUM_BINS - 1);
            acqCoarse, acqFine:     cntTerm = CNT_W'(SAMPLES_PER_HIS - 1);
            scanCoarse, scanFine:   cntTerm = CNT_W'(NUM_BINS);
            default:                cntTerm = '0;
        endcase
    end

    always_comb begin
        nextState = state;
        case (state)
            clearCoarse: if (cntLast) nextState = acqCoarse;
            acqCoarse:   if (transfer && cntLast) nextState = scanCoarse;
            scanCoarse:  if (peakDone) nextState = calcWindow;
            calcWindow:  nextState = clearFine;
            clearFine:   if (cntLast) nextState = acqFine;
            acqFine:     if (transfer && cntLast) nextState = scanFine;
            scanFine:    if (peakDone) nextState = report;
            // held here until the sink takes the code
            report:      if (resultReady) nextState = clearCoarse;
            default:     nextState = clearCoarse;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= clearCoarse;
        end else begin
            state <= nextState;
        end
    end

    // centre of the winning fine bin, frozen through back-pressure
    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultCode <= '0;
        end else if ((state == scanFine) && peakDone) begin
            resultCode <= Np'(int'(thMinus) + FINE_BIN_WIDTH * int'(peakIdx) + 1);
        end
    end

endmodule

// ==== logic/hisBuilderTop.sv ====
`timescale 1ns/1ns

module hisBuilderTop
    import hisPkg::*;
(
    input  logic          clk,
    input  logic          rstN,
    input  logic          sampleValid,
    input  logic [Np-1:0] sampleData,
    output logic          sampleReady,
    output logic          resultValid,
    output logic [Np-1:0] resultCode,
    input  logic          resultReady
);

    // controller to counter
    logic             cntClear;
    logic             cntEn;
    logic [CNT_W-1:0] cntTerm;
    logic [CNT_W-1:0] cntIdx;
    logic             cntLast;

    // controller to datapath
    logic hisNum;
    logic clrEn;
    logic incEn;
    logic scanEn;
    logic scanStart;
    logic winLoad;

    // datapath
    logic [Nb-1:0]      binAddr;
    logic               inWindow;
    logic [peakMax-1:0] binCount;
    logic               countValid;
    logic [Nb-1:0]      peakIdx;
    logic               peakDone;
    logic [Np-1:0]      thMinus;
    logic [Np-1:0]      thPositive;

    hisBuilderFsm fsmU0 (
        .clk(clk), .rstN(rstN),
        .sampleValid(sampleValid), .sampleReady(sampleReady),
        .resultValid(resultValid), .resultReady(resultReady), .resultCode(resultCode),
        .cntLast(cntLast), .cntClear(cntClear), .cntEn(cntEn), .cntTerm(cntTerm),
        .hisNum(hisNum), .clrEn(clrEn), .incEn(incEn), .scanEn(scanEn),
        .scanStart(scanStart), .peakDone(peakDone), .peakIdx(peakIdx),
        .thMinus(thMinus), .winLoad(winLoad)
    );

    hisCounter counterU0 (
        .clk(clk), .rstN(rstN),
        .cntClear(cntClear), .cntEn(cntEn), .cntTerm(cntTerm),
        .cntIdx(cntIdx), .cntLast(cntLast)
    );

    dataFolder folderU0 (
        .sampleData(sampleData), .hisNum(hisNum),
        .thMinus(thMinus), .thPositive(thPositive),
        .binAddr(binAddr), .inWindow(inWindow)
    );

    // memory only needs the low index bits, scan reads stop before NUM_BINS
    binMemory memU0 (
        .clk(clk), .rstN(rstN),
        .clrEn(clrEn), .incEn(incEn), .scanEn(scanEn),
        .binAddr(binAddr), .inWindow(inWindow), .cntIdx(cntIdx[Nb-1:0]),
        .binCount(binCount), .countValid(countValid)
    );

    peakDetecter peakU0 (
        .clk(clk), .rstN(rstN),
        .scanStart(scanStart), .binCount(binCount), .countValid(countValid),
        .peakIdx(peakIdx), .peakDone(peakDone)
    );

    algebraicBlock algU0 (
        .clk(clk), .rstN(rstN),
        .winLoad(winLoad), .peakIdx(peakIdx),
        .thMinus(thMinus), .thPositive(thPositive)
    );

endmodule

// ==== tb/hisBuilderTb.sv ====
`timescale 1ns/1ns

module hisBuilderTb
    import hisPkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int NUM_RANDOM = 20;
    // random runs plus noise, empty fine pass and burst runs
    localparam int NUM_MEAS = NUM_RANDOM + 3;
    localparam int GAP_MAX = 3;
    localparam int STALL_MAX = 6;
    localparam int PASS_LEN = 2 * SAMPLES_PER_HIS;
    localparam int BURST_LEN = 32;
    // worst case per measurement, doubled for clear sweeps and scan tails
    localparam int WATCH_NS = 2 * NUM_MEAS
        * (PASS_LEN * (GAP_MAX + 1) + 3 * NUM_BINS + STALL_MAX) * CLK_PERIOD
        + 20 * CLK_PERIOD;

    logic          clk;
    logic          rstN;
    logic          sampleValid;
    logic [Np-1:0] sampleData;
    logic          sampleReady;
    logic          resultValid;
    logic [Np-1:0] resultCode;
    logic          resultReady;

    int seed;
    // codes of one measurement, coarse pass first
    logic [Np-1:0] codes [PASS_LEN];

    hisBuilderTop dut0 (
        .clk(clk), .rstN(rstN),
        .sampleValid(sampleValid), .sampleData(sampleData), .sampleReady(sampleReady),
        .resultValid(resultValid), .resultCode(resultCode), .resultReady(resultReady)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic checkCode(input string name, input logic [Np-1:0] expected,
                             input logic [Np-1:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // 0 .. n-1 from the seeded stream
    function automatic int randBelow(input int n);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return r % n;
    endfunction

    // target plus jitter, kept inside the code range
    function automatic logic [Np-1:0] nearCode(input int target, input int spread);
        int v;
        v = target + randBelow(2 * spread + 1) - spread;
        if (v < 0) begin
            v = 0;
        end
        if (v > 2 ** Np - 1) begin
            v = 2 ** Np - 1;
        end
        return Np'(v);
    endfunction

    // lowest index wins a tie, all zero gives 0
    function automatic int firstMax(input int hist [NUM_BINS]);
        int best;
        best = 0;
        for (int i = 1; i < NUM_BINS; i++) begin
            if (hist[i] > hist[best]) begin
                best = i;
            end
        end
        return best;
    endfunction

    // fine window start from the coarse peak, clamped at both ends
    function automatic int windowStart(input int peak);
        int start;
        start = peak * COARSE_BIN_WIDTH + COARSE_BIN_WIDTH / 2 - FINE_SPAN / 2;
        if (start < 0) begin
            start = 0;
        end
        if (start > 2 ** Np - FINE_SPAN) begin
            start = 2 ** Np - FINE_SPAN;
        end
        return start;
    endfunction

    // expected code for the measurement held in codes
    function automatic logic [Np-1:0] modelResult();
        int hist [NUM_BINS];
        int start;
        int bin;
        int code;
        for (int b = 0; b < NUM_BINS; b++) begin
            hist[b] = 0;
        end
        for (int i = 0; i < SAMPLES_PER_HIS; i++) begin
            bin = int'(codes[i]) / COARSE_BIN_WIDTH;
            if (hist[bin] < 2 ** peakMax - 1) begin
                hist[bin]++;
            end
        end
        start = windowStart(firstMax(hist));
        for (int b = 0; b < NUM_BINS; b++) begin
            hist[b] = 0;
        end
        // codes off the window still use up pass length
        for (int i = SAMPLES_PER_HIS; i < PASS_LEN; i++) begin
            code = int'(codes[i]);
            if (code >= start && code < start + FINE_SPAN) begin
                bin = (code - start) / FINE_BIN_WIDTH;
                if (hist[bin] < 2 ** peakMax - 1) begin
                    hist[bin]++;
                end
            end
        end
        return Np'(start + FINE_BIN_WIDTH * firstMax(hist) + 1);
    endfunction

    // mode 0 target plus noise, 1 fine pass far off the window, 2 same-code burst
    task automatic genCodes(input int target, input int noisePct, input int mode);
        int pos;
        for (int i = 0; i < PASS_LEN; i++) begin
            pos = i % SAMPLES_PER_HIS;
            if (mode == 2) begin
                if (pos < BURST_LEN) begin
                    codes[i] = Np'(target);
                end else if (pos % 2 == 1) begin
                    // spaced rival in a lower bin, takes a tie from a short burst
                    codes[i] = Np'(target - 8);
                end else begin
                    codes[i] = Np'((target + 2 ** (Np - 1)) % (2 ** Np));
                end
            end else if (mode == 1 && i >= SAMPLES_PER_HIS) begin
                // other half of the code range
                codes[i] = nearCode((target + 2 ** (Np - 1)) % (2 ** Np), 4);
            end else if (randBelow(100) < noisePct) begin
                codes[i] = Np'(randBelow(2 ** Np));
            end else begin
                codes[i] = nearCode(target, 4);
            end
        end
    endtask

    // offer one code after a random gap, hold it until taken
    task automatic sendCode(input logic [Np-1:0] code, input int gapMax);
        logic taken;
        sampleValid = 1'b0;
        repeat (randBelow(gapMax + 1)) begin
            @(posedge clk);
            #1;
        end
        sampleValid = 1'b1;
        sampleData = code;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            // nothing may come out while samples still go in
            checkFlag("resultValid", 1'b0, resultValid);
            taken = sampleReady;
            @(posedge clk);
            #1;
        end
        sampleValid = 1'b0;
    endtask

    task automatic takeResult(input logic [Np-1:0] expected, input int stallMax);
        int stall;
        stall = randBelow(stallMax + 1);
        @(negedge clk);
        while (!resultValid) begin
            @(negedge clk);
        end
        checkCode("resultCode", expected, resultCode);
        checkFlag("sampleReady", 1'b0, sampleReady);
        // sink holds off, result has to sit still
        repeat (stall) begin
            @(posedge clk);
            #1;
            @(negedge clk);
            checkFlag("resultValid", 1'b1, resultValid);
            checkCode("resultCode", expected, resultCode);
            checkFlag("sampleReady", 1'b0, sampleReady);
        end
        @(posedge clk);
        #1;
        resultReady = 1'b1;
        @(posedge clk);
        #1;
        resultReady = 1'b0;
        @(negedge clk);
        // one accept gives exactly one result
        checkFlag("resultValid", 1'b0, resultValid);
        @(posedge clk);
        #1;
    endtask

    task automatic runMeasurement(input int target, input int noisePct, input int mode,
                                  input int gapMax);
        logic [Np-1:0] expected;
        genCodes(target, noisePct, mode);
        expected = modelResult();
        for (int i = 0; i < PASS_LEN; i++) begin
            sendCode(codes[i], gapMax);
        end
        takeResult(expected, STALL_MAX);
    endtask

    initial begin
        int target;
        seed = 32'h76b7cbd2;
        rstN = 1'b0;
        sampleValid = 1'b0;
        sampleData = '0;
        resultReady = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        checkFlag("sampleReady", 1'b0, sampleReady);
        checkFlag("resultValid", 1'b0, resultValid);
        @(posedge clk);
        #1;
        // first four targets sit at the range ends, window gets clamped
        for (int m = 0; m < NUM_RANDOM; m++) begin
            case (m)
                0: target = 2;
                1: target = 2 ** Np - 3;
                2: target = 20;
                3: target = 2 ** Np - 25;
                default: target = randBelow(2 ** Np);
            endcase
            runMeasurement(target, 20, 0, GAP_MAX);
        end
        // heavy noise, most fine codes miss the window
        runMeasurement(randBelow(2 ** Np), 60, 0, GAP_MAX);
        // empty fine histogram
        runMeasurement(500, 0, 1, GAP_MAX);
        // back to back, same bin, no gaps
        runMeasurement(300, 0, 2, 0);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(WATCH_NS);
        $display("timeout, the run did not finish within %0d ns", WATCH_NS);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== project.f ====
logic/hisPkg.sv
logic/dataFolder.sv
logic/hisCounter.sv
logic/binMemory.sv
logic/peakDetecter.sv
logic/algebraicBlock.sv
logic/hisBuilderFsm.sv
logic/hisBuilderTop.sv
tb/hisBuilderTb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f project.f --top-module hisBuilderTb \
    --Mdir obj_dir -o simv > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "simulation passed"
